// ==== bench/mips_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "mips_cfg.svh"

module mips_tb;

    import mips_pkg::*;

    logic  r_clk;
    logic  reset;
    logic  clk_enable;
    word_t instr_readdata;
    word_t data_readdata;
    logic  active;
    word_t register_v0;
    word_t instr_address;
    word_t data_address;
    logic  data_write;
    logic  data_read;
    word_t data_writedata;

    word_t imem [64];
    word_t dmem [64];
    word_t imem_offset;
    int    prog_len;
    logic [31:0] lfsr_state = 32'hfd30_3de6;
    int    error_count = 0;
    int    errors_at_start;
    int    tests_run = 0;
    int    tests_bad = 0;
    string cur_name;

    mips_cpu_harvard uut (
        .r_clk          (r_clk),
        .reset          (reset),
        .clk_enable     (clk_enable),
        .instr_readdata (instr_readdata),
        .data_readdata  (data_readdata),
        .active         (active),
        .register_v0    (register_v0),
        .instr_address  (instr_address),
        .data_address   (data_address),
        .data_write     (data_write),
        .data_read      (data_read),
        .data_writedata (data_writedata)
    );

    always #10 r_clk = ~r_clk;

    // instruction memory starts at the reset vector, anything outside reads as a nop.
    assign imem_offset    = instr_address - `MIPS_RESET_VECTOR;
    assign instr_readdata = (imem_offset < 32'd256) ? imem[imem_offset[7:2]] : '0;

    // data memory answers a read one enabled cycle later.
    always @(posedge r_clk) begin
        if (clk_enable && data_write) begin
            dmem[data_address[7:2]] <= data_writedata;
        end
        if (clk_enable && data_read) begin
            data_readdata <= dmem[data_address[7:2]];
        end
    end

    function automatic logic lfsr_step();
        logic fb;
        fb = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
        lfsr_state = {lfsr_state[30:0], fb};
        return fb;
    endfunction

    function automatic word_t rand_bits(input int n);
        word_t v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            v = {v[30:0], lfsr_step()};
        end
        return v;
    endfunction

    function automatic word_t fill_word(input word_t addr);
        return (addr * 32'h9e37_79b1) ^ 32'h5a5a_a5a5;
    endfunction

    function automatic word_t asm_r(input reg_addr_t rs, input reg_addr_t rt,
                                    input reg_addr_t rd, input logic [4:0] sh,
                                    input funct_t fn);
        return {OP_SPECIAL, rs, rt, rd, sh, fn};
    endfunction

    function automatic word_t asm_i(input opcode_t op, input reg_addr_t rs,
                                    input reg_addr_t rt, input logic [15:0] imm);
        return {op, rs, rt, imm};
    endfunction

    function automatic word_t asm_j(input word_t target);
        return {OP_J, target[27:2]};
    endfunction

    task automatic clear_program();
        for (int i = 0; i < 64; i++) begin
            imem[i] = '0;
        end
        prog_len = 0;
    endtask

    task automatic emit(input word_t instr);
        imem[prog_len] = instr;
        prog_len++;
    endtask

    // lui followed by ori builds any 32-bit constant.
    task automatic emit_const(input reg_addr_t rt, input word_t value);
        emit(asm_i(OP_LUI, 5'd0, rt, value[31:16]));
        emit(asm_i(OP_ORI, rt, rt, value[15:0]));
    endtask

    task automatic fill_data_memory();
        for (int i = 0; i < 64; i++) begin
            dmem[i] = fill_word(i * 4);
        end
    endtask

    task automatic apply_reset();
        @(negedge r_clk);
        reset      = 1'b1;
        clk_enable = 1'b1;
        fill_data_memory();
        repeat (8) @(negedge r_clk);
        reset = 1'b0;
    endtask

    // with stall set, clk_enable drops for random stretches of one to eight cycles.
    task automatic run_to_halt(input int limit, input bit stall);
        int cycles;
        int hold;
        cycles = 0;
        hold   = 0;
        while (active && cycles < limit) begin
            @(negedge r_clk);
            if (stall) begin
                if (hold > 0) begin
                    hold--;
                    clk_enable = 1'b0;
                end else if (rand_bits(2) == 0) begin
                    hold       = rand_bits(3);
                    clk_enable = 1'b0;
                end else begin
                    clk_enable = 1'b1;
                end
            end
            cycles++;
        end
        clk_enable = 1'b1;
        if (active) begin
            $display("timeout: core still active after %0d cycles in %s", limit, cur_name);
            $display("Test failed");
            $finish;
        end
    endtask

    task automatic wait_for_store(input int limit);
        int cycles;
        cycles = 0;
        while (!data_write && cycles < limit) begin
            @(negedge r_clk);
            cycles++;
        end
        if (!data_write) begin
            $display("timeout: no store strobe after %0d cycles in %s", limit, cur_name);
            $display("Test failed");
            $finish;
        end
    endtask

    task automatic check_word(input string what, input word_t got, input word_t exp);
        if (got !== exp) begin
            $display("[ERROR] %0t ns: %s: got %h, expected %h", $time, what, got, exp);
            error_count++;
        end
    endtask

    task automatic check_bit(input string what, input logic got, input logic exp);
        if (got !== exp) begin
            $display("[ERROR] %0t ns: %s: got %b, expected %b", $time, what, got, exp);
            error_count++;
        end
    endtask

    task automatic begin_test(input string name);
        cur_name        = name;
        errors_at_start = error_count;
    endtask

    task automatic end_test();
        tests_run++;
        if (error_count != errors_at_start) begin
            tests_bad++;
            $display("[%s] %0d mismatches", cur_name, error_count - errors_at_start);
        end else begin
            $display("[%s] ok", cur_name);
        end
    endtask

    function automatic string op_name(input int op);
        case (op)
            0: return "addu";
            1: return "subu";
            2: return "and";
            3: return "or";
            4: return "xor";
            5: return "slt";
            6: return "sll";
            7: return "srl";
            8: return "addiu";
            default: return "andi";
        endcase
    endfunction

    function automatic word_t op_instr(input int op, input logic [4:0] sh,
                                       input logic [15:0] imm);
        case (op)
            0: return asm_r(5'd8, 5'd9, 5'd2, 5'd0, FN_ADDU);
            1: return asm_r(5'd8, 5'd9, 5'd2, 5'd0, FN_SUBU);
            2: return asm_r(5'd8, 5'd9, 5'd2, 5'd0, FN_AND);
            3: return asm_r(5'd8, 5'd9, 5'd2, 5'd0, FN_OR);
            4: return asm_r(5'd8, 5'd9, 5'd2, 5'd0, FN_XOR);
            5: return asm_r(5'd8, 5'd9, 5'd2, 5'd0, FN_SLT);
            6: return asm_r(5'd0, 5'd9, 5'd2, sh, FN_SLL);
            7: return asm_r(5'd0, 5'd9, 5'd2, sh, FN_SRL);
            8: return asm_i(OP_ADDIU, 5'd8, 5'd2, imm);
            default: return asm_i(OP_ANDI, 5'd8, 5'd2, imm);
        endcase
    endfunction

    // result of each operation as the MIPS32 manual defines it.
    function automatic word_t op_expect(input int op, input word_t a, input word_t b,
                                        input logic [4:0] sh, input logic [15:0] imm);
        case (op)
            0: return a + b;
            1: return a - b;
            2: return a & b;
            3: return a | b;
            4: return a ^ b;
            5: return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            6: return b << sh;
            7: return b >> sh;
            8: return a + {{16{imm[15]}}, imm};
            default: return a & {16'h0000, imm};
        endcase
    endfunction

    task automatic test_reset_state();
        begin_test("reset_state");
        clear_program();
        apply_reset();
        check_bit("active after reset", active, 1'b1);
        check_word("v0 after reset", register_v0, '0);
        check_word("pc after reset", instr_address, `MIPS_RESET_VECTOR);
        check_bit("data_read after reset", data_read, 1'b0);
        check_bit("data_write after reset", data_write, 1'b0);
        end_test();
    endtask

    task automatic test_alu_ops();
        word_t a;
        word_t b;
        logic [4:0] sh;
        logic [15:0] imm;
        begin_test("alu_ops");
        for (int op = 0; op < 10; op++) begin
            a   = rand_bits(32);
            b   = rand_bits(32);
            sh  = rand_bits(5);
            imm = rand_bits(16);
            clear_program();
            emit_const(5'd8, a);
            emit_const(5'd9, b);
            emit(op_instr(op, sh, imm));
            emit(asm_r(5'd0, 5'd0, 5'd0, 5'd0, FN_JR));
            apply_reset();
            run_to_halt(200, 1'b0);
            check_word($sformatf("v0 after %s", op_name(op)), register_v0,
                       op_expect(op, a, b, sh, imm));
        end
        end_test();
    endtask

    task automatic test_store_load_copy();
        word_t w;
        begin_test("store_load_copy");
        w = rand_bits(32);
        clear_program();
        emit_const(5'd8, w);
        emit(asm_i(OP_SW, 5'd0, 5'd8, 16'h0010));
        emit(asm_i(OP_LW, 5'd0, 5'd11, 16'h0010));
        emit(asm_i(OP_SW, 5'd0, 5'd11, 16'h0024));
        emit(asm_i(OP_LW, 5'd0, 5'd2, 16'h0024));
        emit(asm_r(5'd0, 5'd0, 5'd0, 5'd0, FN_JR));
        apply_reset();
        wait_for_store(200);
        check_word("store address", data_address, 32'h0000_0010);
        check_word("store data", data_writedata, w);
        run_to_halt(200, 1'b0);
        check_word("v0 after copy", register_v0, w);
        check_word("memory at 0x10", dmem[4], w);
        check_word("memory at 0x24", dmem[9], w);
        check_word("memory at 0x20", dmem[8], fill_word(32'h20));
        end_test();
    endtask

    task automatic test_branch_loop();
        word_t n;
        begin_test("branch_loop");
        n = rand_bits(4) + 2;
        clear_program();
        emit(asm_i(OP_ADDIU, 5'd0, 5'd8, n[15:0]));
        emit(asm_i(OP_ADDIU, 5'd0, 5'd2, 16'h0000));
        emit(asm_i(OP_BEQ, 5'd0, 5'd0, 16'd1));
        emit(asm_i(OP_ADDIU, 5'd0, 5'd2, 16'h5555));
        emit(asm_r(5'd2, 5'd8, 5'd2, 5'd0, FN_ADDU));
        emit(asm_i(OP_ADDIU, 5'd8, 5'd8, 16'hffff));
        // branch back three words from the delay-free next address.
        emit(asm_i(OP_BNE, 5'd8, 5'd0, 16'hfffd));
        emit(asm_j(`MIPS_RESET_VECTOR + 32'd36));
        emit(asm_i(OP_ADDIU, 5'd0, 5'd2, 16'h6666));
        emit(asm_r(5'd0, 5'd0, 5'd0, 5'd0, FN_JR));
        apply_reset();
        run_to_halt(1000, 1'b0);
        check_word($sformatf("v0 after sum to %0d", n), register_v0, n * (n + 1) / 2);
        end_test();
    endtask

    task automatic test_zero_reg_and_stalls();
        word_t a;
        begin_test("zero_reg_stalls");
        a = rand_bits(32);
        clear_program();
        emit_const(5'd8, a);
        emit(asm_r(5'd8, 5'd0, 5'd2, 5'd0, FN_ADDU));
        emit(asm_i(OP_ADDIU, 5'd0, 5'd0, 16'h1234));
        emit(asm_i(OP_LUI, 5'd0, 5'd0, 16'hffff));
        emit(asm_i(OP_LW, 5'd0, 5'd0, 16'h0040));
        emit(asm_r(5'd2, 5'd0, 5'd2, 5'd0, FN_ADDU));
        emit(asm_r(5'd0, 5'd0, 5'd0, 5'd0, FN_JR));
        apply_reset();
        run_to_halt(2000, 1'b1);
        check_word("v0 after writes to r0", register_v0, a);
        check_word("pc after halt", instr_address, `MIPS_HALT_ADDR);
        end_test();
    endtask

    task automatic test_halt_on_jr();
        begin_test("halt_on_jr");
        clear_program();
        emit(asm_i(OP_ADDIU, 5'd0, 5'd2, 16'h0123));
        emit(asm_r(5'd12, 5'd0, 5'd0, 5'd0, FN_JR));
        emit(asm_i(OP_ADDIU, 5'd0, 5'd2, 16'h0456));
        emit(asm_i(OP_SW, 5'd0, 5'd2, 16'h0030));
        apply_reset();
        run_to_halt(200, 1'b0);
        for (int i = 0; i < 20; i++) begin
            @(negedge r_clk);
            check_bit("active while halted", active, 1'b0);
            check_word("pc while halted", instr_address, 32'h0000_0000);
            check_bit("data_write while halted", data_write, 1'b0);
            check_bit("data_read while halted", data_read, 1'b0);
        end
        check_word("v0 after halt", register_v0, 32'h0000_0123);
        check_word("memory at 0x30", dmem[12], fill_word(32'h30));
        end_test();
    endtask

    initial begin
        r_clk         = 1'b0;
        reset         = 1'b1;
        clk_enable    = 1'b0;
        data_readdata = '0;
        clear_program();
        fill_data_memory();

        test_reset_state();
        test_alu_ops();
        test_store_load_copy();
        test_branch_loop();
        test_zero_reg_and_stalls();
        test_halt_on_jr();

        $display("tests run %0d, tests with mismatches %0d, mismatches %0d",
                 tests_run, tests_bad, error_count);
        if (error_count == 0) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== design/alu.sv ====
`timescale 1ns/1ps
`default_nettype none

module alu (
    input  wire mips_pkg::alu_op_t alu_op,
    input  wire mips_pkg::word_t   operand_a,
    input  wire mips_pkg::word_t   operand_b,
    input  wire logic [4:0]        shamt,
    output mips_pkg::word_t        result,
    output logic                   zero
);

    import mips_pkg::*;

    always_comb begin
        case (alu_op)
            ALU_ADD: begin
                result = operand_a + operand_b;
            end
            ALU_SUB: begin
                result = operand_a - operand_b;
            end
            ALU_AND: begin
                result = operand_a & operand_b;
            end
            ALU_OR: begin
                result = operand_a | operand_b;
            end
            ALU_XOR: begin
                result = operand_a ^ operand_b;
            end
            ALU_SLT: begin
                result = {31'd0, $signed(operand_a) < $signed(operand_b)};
            end
            // shifts act on the rt operand, as MIPS defines them.
            ALU_SLL: begin
                result = operand_b << shamt;
            end
            ALU_SRL: begin
                result = operand_b >> shamt;
            end
            ALU_LUI: begin
                result = {operand_b[15:0], 16'h0000};
            end
            default: begin
                result = '0;
            end
        endcase
    end

    // the branch compare uses ALU_SUB, so zero means the operands are equal.
    assign zero = (result == '0);

endmodule

`default_nettype wire

// ==== design/control_fsm.sv ====
`timescale 1ns/1ps
`default_nettype none

module control_fsm (
    input  wire logic              r_clk,
    input  wire logic              reset,
    input  wire logic              clk_enable,
    input  wire mips_pkg::opcode_t opcode,
    input  wire mips_pkg::funct_t  funct,
    input  wire logic              alu_zero,
    input  wire logic              halt,
    output logic                   active,
    output logic                   ir_load,
    output logic                   reg_write_en,
    output logic                   write_sel_rt,
    output logic                   writeback_mem,
    output logic                   operand_b_imm,
    output logic                   imm_zero_extend,
    output mips_pkg::alu_op_t      alu_op,
    output logic                   pc_step,
    output logic                   pc_branch,
    output logic                   pc_jump,
    output logic                   pc_jump_reg,
    output logic                   data_read,
    output logic                   data_write
);

    import mips_pkg::*;

    cpu_state_t state;
    cpu_state_t next_state;
    logic       in_exec;
    logic       dec_write;
    logic       is_load;
    logic       is_store;
    logic       is_beq;
    logic       is_bne;
    logic       is_j;
    logic       is_jr;
    logic       take_branch;

    // decode is purely combinational, the state gates it below.
    always_comb begin
        dec_write       = 1'b0;
        write_sel_rt    = 1'b1;
        operand_b_imm   = 1'b1;
        imm_zero_extend = 1'b0;
        alu_op          = ALU_ADD;
        is_load         = 1'b0;
        is_store        = 1'b0;
        is_beq          = 1'b0;
        is_bne          = 1'b0;
        is_j            = 1'b0;
        is_jr           = 1'b0;
        case (opcode)
            OP_SPECIAL: begin
                write_sel_rt  = 1'b0;
                operand_b_imm = 1'b0;
                dec_write     = 1'b1;
                case (funct)
                    FN_ADDU: alu_op = ALU_ADD;
                    FN_SUBU: alu_op = ALU_SUB;
                    FN_AND:  alu_op = ALU_AND;
                    FN_OR:   alu_op = ALU_OR;
                    FN_XOR:  alu_op = ALU_XOR;
                    FN_SLT:  alu_op = ALU_SLT;
                    FN_SLL:  alu_op = ALU_SLL;
                    FN_SRL:  alu_op = ALU_SRL;
                    FN_JR: begin
                        dec_write = 1'b0;
                        is_jr     = 1'b1;
                    end
                    default: dec_write = 1'b0;
                endcase
            end
            OP_ADDIU: dec_write = 1'b1;
            OP_ANDI: begin
                dec_write       = 1'b1;
                imm_zero_extend = 1'b1;
                alu_op          = ALU_AND;
            end
            OP_ORI: begin
                dec_write       = 1'b1;
                imm_zero_extend = 1'b1;
                alu_op          = ALU_OR;
            end
            OP_LUI: begin
                dec_write = 1'b1;
                alu_op    = ALU_LUI;
            end
            OP_LW: is_load = 1'b1;
            OP_SW: is_store = 1'b1;
            OP_BEQ, OP_BNE: begin
                operand_b_imm = 1'b0;
                alu_op        = ALU_SUB;
                is_beq        = (opcode == OP_BEQ);
                is_bne        = (opcode == OP_BNE);
            end
            OP_J: is_j = 1'b1;
            default: dec_write = 1'b0;
        endcase
    end

    assign in_exec     = (state == EXEC);
    assign take_branch = (is_beq && alu_zero) || (is_bne && !alu_zero);

    assign active        = (state != HALT);
    assign ir_load       = (state == FETCH);
    assign writeback_mem = (state == LOAD_WB);
    assign reg_write_en  = (in_exec && dec_write) || (state == LOAD_WB);
    assign pc_branch     = in_exec && take_branch;
    assign pc_jump       = in_exec && is_j;
    assign pc_jump_reg   = in_exec && is_jr;
    assign pc_step       = in_exec && !take_branch && !is_j && !is_jr;
    assign data_read     = in_exec && is_load;
    assign data_write    = in_exec && is_store;

    always_comb begin
        case (state)
            FETCH:   next_state = EXEC;
            EXEC: begin
                if (halt) begin
                    next_state = HALT;
                end else if (is_load) begin
                    next_state = LOAD_WB;
                end else begin
                    next_state = FETCH;
                end
            end
            LOAD_WB: next_state = FETCH;
            default: next_state = HALT;
        endcase
    end

    always_ff @(posedge r_clk) begin
        if (reset) begin
            state <= FETCH;
        end else if (clk_enable) begin
            state <= next_state;
        end
    end

    a_strobes_exclusive: assert property (
        @(posedge r_clk) disable iff (reset)
        !(data_read && data_write)
    );

endmodule

`default_nettype wire

// ==== design/mips_cfg.svh ====
`ifndef MIPS_CFG_SVH
`define MIPS_CFG_SVH

// the first instruction is fetched from the boot ROM region.
`define MIPS_RESET_VECTOR 32'hbfc0_0000

// a jump to this address ends the program and drops active.
`define MIPS_HALT_ADDR 32'h0000_0000

// register index of v0, which is exposed for observation.
`define MIPS_V0_REG 5'd2

`endif

// ==== design/mips_cpu_harvard.sv ====
`timescale 1ns/1ps
`default_nettype none

module mips_cpu_harvard (
    input  wire logic            r_clk,
    input  wire logic            reset,
    input  wire logic            clk_enable,
    input  wire mips_pkg::word_t instr_readdata,
    input  wire mips_pkg::word_t data_readdata,
    output logic                 active,
    output mips_pkg::word_t      register_v0,
    output mips_pkg::word_t      instr_address,
    output mips_pkg::word_t      data_address,
    output logic                 data_write,
    output logic                 data_read,
    output mips_pkg::word_t      data_writedata
);

    import mips_pkg::*;

    word_t     ir;
    opcode_t   opcode;
    funct_t    funct;
    reg_addr_t rs;
    reg_addr_t rt;
    reg_addr_t rd;
    reg_addr_t write_reg;
    logic [4:0] shamt;
    word_t     imm_ext;
    word_t     read_data1;
    word_t     read_data2;
    word_t     operand_b;
    word_t     alu_result;
    word_t     write_data;
    word_t     pc;
    alu_op_t   alu_op;
    logic      alu_zero;
    logic      halt;
    logic      ir_load;
    logic      reg_write_en;
    logic      write_sel_rt;
    logic      writeback_mem;
    logic      operand_b_imm;
    logic      imm_zero_extend;
    logic      pc_step;
    logic      pc_branch;
    logic      pc_jump;
    logic      pc_jump_reg;

    // the instruction register is decoded by the FSM, so it starts as a nop.
    always_ff @(posedge r_clk) begin
        if (reset) begin
            ir <= '0;
        end else if (clk_enable && ir_load) begin
            ir <= instr_readdata;
        end
    end

    assign opcode = ir[31:26];
    assign rs     = ir[25:21];
    assign rt     = ir[20:16];
    assign rd     = ir[15:11];
    assign shamt  = ir[10:6];
    assign funct  = ir[5:0];

    assign imm_ext    = imm_zero_extend ? {16'h0000, ir[15:0]} : {{16{ir[15]}}, ir[15:0]};
    assign operand_b  = operand_b_imm ? imm_ext : read_data2;
    assign write_reg  = write_sel_rt ? rt : rd;
    assign write_data = writeback_mem ? data_readdata : alu_result;

    assign instr_address  = pc;
    assign data_address   = alu_result;
    assign data_writedata = read_data2;

    control_fsm u_control (
        .r_clk           (r_clk),
        .reset           (reset),
        .clk_enable      (clk_enable),
        .opcode          (opcode),
        .funct           (funct),
        .alu_zero        (alu_zero),
        .halt            (halt),
        .active          (active),
        .ir_load         (ir_load),
        .reg_write_en    (reg_write_en),
        .write_sel_rt    (write_sel_rt),
        .writeback_mem   (writeback_mem),
        .operand_b_imm   (operand_b_imm),
        .imm_zero_extend (imm_zero_extend),
        .alu_op          (alu_op),
        .pc_step         (pc_step),
        .pc_branch       (pc_branch),
        .pc_jump         (pc_jump),
        .pc_jump_reg     (pc_jump_reg),
        .data_read       (data_read),
        .data_write      (data_write)
    );

    pc_counter u_pc (
        .r_clk         (r_clk),
        .reset         (reset),
        .clk_enable    (clk_enable),
        .pc_step       (pc_step),
        .pc_branch     (pc_branch),
        .pc_jump       (pc_jump),
        .pc_jump_reg   (pc_jump_reg),
        .branch_offset (imm_ext),
        .jump_index    ({6'd0, ir[25:0]}),
        .jump_target   (read_data1),
        .pc            (pc),
        .halt          (halt)
    );

    regfile u_regfile (
        .r_clk         (r_clk),
        .reset         (reset),
        .r_clk_enable  (clk_enable),
        .write_control (reg_write_en),
        .read_reg1     (rs),
        .read_reg2     (rt),
        .write_reg     (write_reg),
        .write_data    (write_data),
        .read_data1    (read_data1),
        .read_data2    (read_data2),
        .register_v0   (register_v0)
    );

    alu u_alu (
        .alu_op    (alu_op),
        .operand_a (read_data1),
        .operand_b (operand_b),
        .shamt     (shamt),
        .result    (alu_result),
        .zero      (alu_zero)
    );

endmodule

`default_nettype wire

// ==== design/mips_pkg.sv ====
`default_nettype none

package mips_pkg;

    typedef logic [31:0] word_t;
    typedef logic [4:0] reg_addr_t;
    typedef logic [5:0] opcode_t;
    typedef logic [5:0] funct_t;
    typedef logic [3:0] alu_op_t;

    typedef enum logic [1:0] {
        FETCH,
        EXEC,
        LOAD_WB,
        HALT
    } cpu_state_t;

    // primary opcodes of the supported subset.
    localparam opcode_t OP_SPECIAL = 6'h00;
    localparam opcode_t OP_J       = 6'h02;
    localparam opcode_t OP_BEQ     = 6'h04;
    localparam opcode_t OP_BNE     = 6'h05;
    localparam opcode_t OP_ADDIU   = 6'h09;
    localparam opcode_t OP_ANDI    = 6'h0c;
    localparam opcode_t OP_ORI     = 6'h0d;
    localparam opcode_t OP_LUI     = 6'h0f;
    localparam opcode_t OP_LW      = 6'h23;
    localparam opcode_t OP_SW      = 6'h2b;

    // function codes used under OP_SPECIAL.
    localparam funct_t FN_SLL  = 6'h00;
    localparam funct_t FN_SRL  = 6'h02;
    localparam funct_t FN_JR   = 6'h08;
    localparam funct_t FN_ADDU = 6'h21;
    localparam funct_t FN_SUBU = 6'h23;
    localparam funct_t FN_AND  = 6'h24;
    localparam funct_t FN_OR   = 6'h25;
    localparam funct_t FN_XOR  = 6'h26;
    localparam funct_t FN_SLT  = 6'h2a;

    localparam alu_op_t ALU_ADD = 4'd0;
    localparam alu_op_t ALU_SUB = 4'd1;
    localparam alu_op_t ALU_AND = 4'd2;
    localparam alu_op_t ALU_OR  = 4'd3;
    localparam alu_op_t ALU_XOR = 4'd4;
    localparam alu_op_t ALU_SLT = 4'd5;
    localparam alu_op_t ALU_SLL = 4'd6;
    localparam alu_op_t ALU_SRL = 4'd7;
    localparam alu_op_t ALU_LUI = 4'd8;

endpackage

`default_nettype wire

// ==== design/pc_counter.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "mips_cfg.svh"

module pc_counter (
    input  wire logic            r_clk,
    input  wire logic            reset,
    input  wire logic            clk_enable,
    input  wire logic            pc_step,
    input  wire logic            pc_branch,
    input  wire logic            pc_jump,
    input  wire logic            pc_jump_reg,
    input  wire mips_pkg::word_t branch_offset,
    input  wire mips_pkg::word_t jump_index,
    input  wire mips_pkg::word_t jump_target,
    output mips_pkg::word_t      pc,
    output logic                 halt
);

    import mips_pkg::*;

    word_t pc_plus4;
    word_t branch_dest;
    word_t jump_dest;

    assign pc_plus4    = pc + 32'd4;
    assign branch_dest = pc_plus4 + {branch_offset[29:0], 2'b00};
    // j keeps the region bits of the next sequential address.
    assign jump_dest   = {pc_plus4[31:28], jump_index[25:0], 2'b00};

    assign halt = (pc_jump && jump_dest == `MIPS_HALT_ADDR)
                || (pc_jump_reg && jump_target == `MIPS_HALT_ADDR);

    always_ff @(posedge r_clk) begin
        if (reset) begin
            pc <= `MIPS_RESET_VECTOR;
        end else if (clk_enable) begin
            if (pc_jump_reg) begin
                pc <= jump_target;
            end else if (pc_jump) begin
                pc <= jump_dest;
            end else if (pc_branch) begin
                pc <= branch_dest;
            end else if (pc_step) begin
                pc <= pc_plus4;
            end
        end
    end

    // jr takes its target from a register, so misaligned values must not appear there.
    a_pc_aligned: assert property (
        @(posedge r_clk) disable iff (reset)
        pc[1:0] == 2'b00
    );

endmodule

`default_nettype wire

// ==== design/regfile.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "mips_cfg.svh"

module regfile (
    input  wire logic              r_clk,
    input  wire logic              reset,
    input  wire logic              r_clk_enable,
    input  wire logic              write_control,
    input  wire mips_pkg::reg_addr_t read_reg1,
    input  wire mips_pkg::reg_addr_t read_reg2,
    input  wire mips_pkg::reg_addr_t write_reg,
    input  wire mips_pkg::word_t     write_data,
    output mips_pkg::word_t          read_data1,
    output mips_pkg::word_t          read_data2,
    output mips_pkg::word_t          register_v0
);

    import mips_pkg::*;

    word_t registers [32];

    // writes to register zero are dropped, so it keeps its reset value.
    always_ff @(posedge r_clk) begin
        if (reset) begin
            for (int i = 0; i < 32; i++) begin
                registers[i] <= '0;
            end
        end else if (r_clk_enable && write_control && write_reg != '0) begin
            registers[write_reg] <= write_data;
        end
    end

    assign read_data1  = registers[read_reg1];
    assign read_data2  = registers[read_reg2];
    assign register_v0 = registers[`MIPS_V0_REG];

    a_zero_reg_reads_zero: assert property (
        @(posedge r_clk) disable iff (reset)
        (read_reg1 == '0) |-> (read_data1 == '0)
    );

endmodule

`default_nettype wire

// ==== vlog.f ====
+incdir+design
design/mips_pkg.sv
design/regfile.sv
design/pc_counter.sv
design/alu.sv
design/control_fsm.sv
design/mips_cpu_harvard.sv
bench/mips_tb.sv
